// File: src/jtag_pkg.sv
package jtag_pkg;

  localparam int IR_LEN     = 5;
  localparam int IDCODE_LEN = 32;
  localparam int USER_LEN   = 16;

  // Bit 0 set, bit 1 clear as 1149.1 requires
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 5'b00001;

  localparam logic [IDCODE_LEN-1:0] IDCODE_VALUE = 32'h2B8C_E04D;

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET = 4'h0,
    RUN_TEST_IDLE    = 4'h1,
    SELECT_DR_SCAN   = 4'h2,
    CAPTURE_DR       = 4'h3,
    SHIFT_DR         = 4'h4,
    EXIT1_DR         = 4'h5,
    PAUSE_DR         = 4'h6,
    EXIT2_DR         = 4'h7,
    UPDATE_DR        = 4'h8,
    SELECT_IR_SCAN   = 4'h9,
    CAPTURE_IR       = 4'hA,
    SHIFT_IR         = 4'hB,
    EXIT1_IR         = 4'hC,
    PAUSE_IR         = 4'hD,
    EXIT2_IR         = 4'hE,
    UPDATE_IR        = 4'hF
  } tap_state_t;

  // Codes not listed fall back to bypass
  typedef enum logic [IR_LEN-1:0] {
    OP_IDCODE = 5'b00001,
    OP_USER   = 5'b01000,
    OP_BYPASS = 5'b11111
  } jtag_instr_t;

endpackage

// File: src/tap_fsm.sv
`timescale 1ns/1ps

module tap_fsm import jtag_pkg::*; (
  input  logic TCK,
  input  logic TRST,
  input  logic tms,
  output logic capture_ir,
  output logic shift_ir,
  output logic update_ir,
  output logic capture_dr,
  output logic shift_dr,
  output logic update_dr,
  output logic in_reset
);

  tap_state_t state;
  tap_state_t state_nxt;

  always_ff @(posedge TCK or negedge TRST) begin
    if (!TRST) begin
      state <= TEST_LOGIC_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  // Standard 1149.1 transition table
  always_comb begin
    case (state)
      TEST_LOGIC_RESET: state_nxt = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_nxt = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_nxt = tms ? SELECT_IR_SCAN : CAPTURE_DR;
      CAPTURE_DR:       state_nxt = tms ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_nxt = tms ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_nxt = tms ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_nxt = tms ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_nxt = tms ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_nxt = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_nxt = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_nxt = tms ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_nxt = tms ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_nxt = tms ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_nxt = tms ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_nxt = tms ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        state_nxt = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      default:          state_nxt = TEST_LOGIC_RESET;
    endcase
  end

  // Strobes stay high for the whole cycle spent in the state
  assign capture_ir = (state == CAPTURE_IR);
  assign shift_ir   = (state == SHIFT_IR);
  assign update_ir  = (state == UPDATE_IR);
  assign capture_dr = (state == CAPTURE_DR);
  assign shift_dr   = (state == SHIFT_DR);
  assign update_dr  = (state == UPDATE_DR);
  assign in_reset   = (state == TEST_LOGIC_RESET);

endmodule

// File: src/instr_reg.sv
`timescale 1ns/1ps

module instr_reg import jtag_pkg::*; (
  input  logic TCK,
  input  logic TRST,
  input  logic tdi,
  input  logic capture_ir,
  input  logic shift_ir,
  input  logic update_ir,
  input  logic in_reset,
  output logic ir_so,
  output logic sel_idcode,
  output logic sel_user
);

  logic [IR_LEN-1:0] ir_shift;
  jtag_instr_t       ir_cur;

  // Shift stage, TDI in at the top, LSB out first
  always_ff @(posedge TCK) begin
    if (capture_ir) begin
      ir_shift <= IR_CAPTURE;
    end else if (shift_ir) begin
      ir_shift <= {tdi, ir_shift[IR_LEN-1:1]};
    end
  end

  assign ir_so = ir_shift[0];

  // Update stage
  always_ff @(posedge TCK or negedge TRST) begin
    if (!TRST) begin
      ir_cur <= OP_IDCODE;
    end else if (in_reset) begin
      ir_cur <= OP_IDCODE;
    end else if (update_ir) begin
      ir_cur <= jtag_instr_t'(ir_shift);  // unknown codes kept as is
    end
  end

  always_comb begin
    sel_idcode = 1'b0;
    sel_user   = 1'b0;
    case (ir_cur)
      OP_IDCODE: sel_idcode = 1'b1;
      OP_USER:   sel_user   = 1'b1;
      default: begin
        // Bypass, nothing selected
        sel_idcode = 1'b0;
        sel_user   = 1'b0;
      end
    endcase
  end

endmodule

// File: src/idcode_reg.sv
`timescale 1ns/1ps

module idcode_reg import jtag_pkg::*; (
  input  logic TCK,
  input  logic TRST,
  input  logic tdi,
  input  logic sel_idcode,
  input  logic capture_dr,
  input  logic shift_dr,
  output logic idcode_so
);

  logic [IDCODE_LEN-1:0] id_shift;

  // Loaded with the code at reset as well as on capture
  always_ff @(posedge TCK or negedge TRST) begin
    if (!TRST) begin
      id_shift <= IDCODE_VALUE;
    end else if (sel_idcode) begin
      if (capture_dr) begin
        id_shift <= IDCODE_VALUE;
      end else if (shift_dr) begin
        id_shift <= {tdi, id_shift[IDCODE_LEN-1:1]};
      end
    end
  end

  assign idcode_so = id_shift[0];

endmodule

// File: src/user_reg.sv
`timescale 1ns/1ps

module user_reg import jtag_pkg::*; (
  input  logic                TCK,
  input  logic                TRST,
  input  logic                tdi,
  input  logic                sel_user,
  input  logic                capture_dr,
  input  logic                shift_dr,
  input  logic                update_dr,
  input  logic                in_reset,
  input  logic [USER_LEN-1:0] user_status,
  output logic                user_so,
  output logic [USER_LEN-1:0] user_data
);

  logic [USER_LEN-1:0] usr_shift;

  // Status from the chip in, new control word out
  always_ff @(posedge TCK) begin
    if (sel_user) begin
      if (capture_dr) begin
        usr_shift <= user_status;
      end else if (shift_dr) begin
        usr_shift <= {tdi, usr_shift[USER_LEN-1:1]};
      end
    end
  end

  assign user_so = usr_shift[0];

  // Control word only moves on update under OP_USER
  always_ff @(posedge TCK or negedge TRST) begin
    if (!TRST) begin
      user_data <= '0;
    end else if (in_reset) begin
      user_data <= '0;
    end else if (update_dr && sel_user) begin
      user_data <= usr_shift;
    end
  end

endmodule

// File: src/scan_out_mux.sv
`timescale 1ns/1ps

module scan_out_mux (
  input  logic TCK,
  input  logic TRST,
  input  logic tdi,
  input  logic sel_idcode,
  input  logic sel_user,
  input  logic capture_dr,
  input  logic shift_dr,
  input  logic shift_ir,
  input  logic ir_so,
  input  logic idcode_so,
  input  logic user_so,
  output logic tdo,
  output logic tdo_en
);

  logic sel_bypass;
  logic bypass_bit;
  logic dr_so;
  logic scan_bit;

  assign sel_bypass = !sel_idcode && !sel_user;

  always_ff @(posedge TCK) begin
    if (sel_bypass) begin
      if (capture_dr) begin
        bypass_bit <= 1'b0;
      end else if (shift_dr) begin
        bypass_bit <= tdi;
      end
    end
  end

  assign dr_so = sel_idcode ? idcode_so :
                 sel_user   ? user_so   : bypass_bit;

  // Held low outside shift states
  assign scan_bit = shift_ir ? ir_so :
                    shift_dr ? dr_so : 1'b0;

  // Retime on the falling edge
  always_ff @(negedge TCK or negedge TRST) begin
    if (!TRST) begin
      tdo    <= 1'b0;
      tdo_en <= 1'b0;
    end else begin
      tdo    <= scan_bit;
      tdo_en <= shift_ir | shift_dr;
    end
  end

endmodule

// File: src/jtag_tap_top.sv
`timescale 1ns/1ps

module jtag_tap_top import jtag_pkg::*; (
  input  logic                TCK,
  input  logic                TRST,
  input  logic                tms,
  input  logic                tdi,
  input  logic [USER_LEN-1:0] user_status,
  output logic                tdo,
  output logic                tdo_en,
  output logic [USER_LEN-1:0] user_data
);

  logic capture_ir;
  logic shift_ir;
  logic update_ir;
  logic capture_dr;
  logic shift_dr;
  logic update_dr;
  logic in_reset;
  logic sel_idcode;
  logic sel_user;
  logic ir_so;
  logic idcode_so;
  logic user_so;

  tap_fsm u_tap_fsm (
    .TCK        (TCK),
    .TRST       (TRST),
    .tms        (tms),
    .capture_ir (capture_ir),
    .shift_ir   (shift_ir),
    .update_ir  (update_ir),
    .capture_dr (capture_dr),
    .shift_dr   (shift_dr),
    .update_dr  (update_dr),
    .in_reset   (in_reset)
  );

  // Instruction register steers the data registers
  instr_reg u_instr_reg (
    .TCK        (TCK),
    .TRST       (TRST),
    .tdi        (tdi),
    .capture_ir (capture_ir),
    .shift_ir   (shift_ir),
    .update_ir  (update_ir),
    .in_reset   (in_reset),
    .ir_so      (ir_so),
    .sel_idcode (sel_idcode),
    .sel_user   (sel_user)
  );

  idcode_reg u_idcode_reg (
    .TCK        (TCK),
    .TRST       (TRST),
    .tdi        (tdi),
    .sel_idcode (sel_idcode),
    .capture_dr (capture_dr),
    .shift_dr   (shift_dr),
    .idcode_so  (idcode_so)
  );

  user_reg u_user_reg (
    .TCK         (TCK),
    .TRST        (TRST),
    .tdi         (tdi),
    .sel_user    (sel_user),
    .capture_dr  (capture_dr),
    .shift_dr    (shift_dr),
    .update_dr   (update_dr),
    .in_reset    (in_reset),
    .user_status (user_status),
    .user_so     (user_so),
    .user_data   (user_data)
  );

  scan_out_mux u_scan_out_mux (
    .TCK        (TCK),
    .TRST       (TRST),
    .tdi        (tdi),
    .sel_idcode (sel_idcode),
    .sel_user   (sel_user),
    .capture_dr (capture_dr),
    .shift_dr   (shift_dr),
    .shift_ir   (shift_ir),
    .ir_so      (ir_so),
    .idcode_so  (idcode_so),
    .user_so    (user_so),
    .tdo        (tdo),
    .tdo_en     (tdo_en)
  );

endmodule

// File: verification/jtag_tap_assert.sv
`timescale 1ns/1ps

module jtag_tap_assert import jtag_pkg::*; (
  input logic                TCK,
  input logic                TRST,
  input logic                tdo_en,
  input logic                shift_ir,
  input logic                shift_dr,
  input logic                update_dr,
  input logic                in_reset,
  input logic                sel_idcode,
  input logic                sel_user,
  input logic [USER_LEN-1:0] user_data
);

  // tdo_en was set at the falling edge inside the current state
  a_tdo_en: assert property (@(posedge TCK) disable iff (!TRST)
    tdo_en == (shift_ir || shift_dr))
    else $error("tdo_en does not follow the shift states");

  a_one_select: assert property (@(posedge TCK) !(sel_idcode && sel_user))
    else $error("sel_idcode and sel_user both high");

  a_user_data: assert property (@(posedge TCK) disable iff (!TRST)
    $changed(user_data) |-> $past(update_dr && sel_user) || $past(in_reset))
    else $error("user_data changed without an update under OP_USER");

endmodule

bind jtag_tap_top jtag_tap_assert u_jtag_tap_assert (
  .TCK        (TCK),
  .TRST       (TRST),
  .tdo_en     (tdo_en),
  .shift_ir   (shift_ir),
  .shift_dr   (shift_dr),
  .update_dr  (update_dr),
  .in_reset   (in_reset),
  .sel_idcode (sel_idcode),
  .sel_user   (sel_user),
  .user_data  (user_data)
);

// File: verification/jtag_tap_model.svh
`ifndef JTAG_TAP_MODEL_SVH
`define JTAG_TAP_MODEL_SVH

tap_state_t            m_state;
jtag_instr_t           m_ir;
logic [IR_LEN-1:0]     m_ir_shift;
logic [IDCODE_LEN-1:0] m_id_shift;
logic [USER_LEN-1:0]   m_usr_shift;
logic [USER_LEN-1:0]   m_user_data;
logic                  m_bypass;

function automatic tap_state_t next_tap_state(tap_state_t s, logic t);
  case (s)
    TEST_LOGIC_RESET: return t ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
    RUN_TEST_IDLE:    return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;
    SELECT_DR_SCAN:   return t ? SELECT_IR_SCAN : CAPTURE_DR;
    CAPTURE_DR:       return t ? EXIT1_DR : SHIFT_DR;
    SHIFT_DR:         return t ? EXIT1_DR : SHIFT_DR;
    EXIT1_DR:         return t ? UPDATE_DR : PAUSE_DR;
    PAUSE_DR:         return t ? EXIT2_DR : PAUSE_DR;
    EXIT2_DR:         return t ? UPDATE_DR : SHIFT_DR;
    SELECT_IR_SCAN:   return t ? TEST_LOGIC_RESET : CAPTURE_IR;
    CAPTURE_IR:       return t ? EXIT1_IR : SHIFT_IR;
    SHIFT_IR:         return t ? EXIT1_IR : SHIFT_IR;
    EXIT1_IR:         return t ? UPDATE_IR : PAUSE_IR;
    PAUSE_IR:         return t ? EXIT2_IR : PAUSE_IR;
    EXIT2_IR:         return t ? UPDATE_IR : SHIFT_IR;
    default:          return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;  // Both update states
  endcase
endfunction

task automatic reset_model();
  m_state     = TEST_LOGIC_RESET;
  m_ir        = OP_IDCODE;
  m_user_data = '0;
  m_id_shift  = IDCODE_VALUE;
endtask

// Register effects at the rising edge that ends the current state
task automatic model_step(input logic tms_v, input logic tdi_v);
  case (m_state)
    TEST_LOGIC_RESET: begin
      m_ir        = OP_IDCODE;
      m_user_data = '0;
    end
    CAPTURE_IR: m_ir_shift = IR_CAPTURE;
    SHIFT_IR:   m_ir_shift = {tdi_v, m_ir_shift[IR_LEN-1:1]};
    UPDATE_IR:  m_ir = jtag_instr_t'(m_ir_shift);
    // Unselected registers are never read before their next capture
    CAPTURE_DR: begin
      m_bypass    = 1'b0;
      m_id_shift  = IDCODE_VALUE;
      m_usr_shift = user_status;
    end
    SHIFT_DR: begin
      if (m_ir == OP_IDCODE) m_id_shift = {tdi_v, m_id_shift[IDCODE_LEN-1:1]};
      else if (m_ir == OP_USER) m_usr_shift = {tdi_v, m_usr_shift[USER_LEN-1:1]};
      else m_bypass = tdi_v;
    end
    UPDATE_DR: if (m_ir == OP_USER) m_user_data = m_usr_shift;
    default: ;
  endcase
  m_state = next_tap_state(m_state, tms_v);
endtask

function automatic logic expected_tdo();
  if (m_state == SHIFT_IR) return m_ir_shift[0];
  if (m_state != SHIFT_DR) return 1'b0;
  if (m_ir == OP_IDCODE) return m_id_shift[0];
  if (m_ir == OP_USER) return m_usr_shift[0];
  return m_bypass;
endfunction

// One TCK cycle, entered and left 0.5 ns after a rising edge
task automatic clock_cycle(input logic tms_v, input logic tdi_v, output logic tdo_bit);
  logic exp_tdo;
  logic exp_en;
  tms = tms_v;
  tdi = tdi_v;
  exp_tdo = expected_tdo();
  exp_en  = (m_state == SHIFT_IR) || (m_state == SHIFT_DR);
  @(negedge TCK);
  #1;
  if (tdo !== exp_tdo) report_mismatch("tdo", 64'(exp_tdo), 64'(tdo));
  if (tdo_en !== exp_en) report_mismatch("tdo_en", 64'(exp_en), 64'(tdo_en));
  if (user_data !== m_user_data) report_mismatch("user_data", 64'(m_user_data), 64'(user_data));
  tdo_bit = tdo;
  @(posedge TCK);
  model_step(tms_v, tdi_v);
  #0.5;
endtask

function automatic logic tms_toward(tap_state_t cur, tap_state_t target);
  case (cur)
    TEST_LOGIC_RESET: return 1'b0;
    SELECT_DR_SCAN:   return target >= SELECT_IR_SCAN;
    SELECT_IR_SCAN:   return target < SELECT_IR_SCAN;
    CAPTURE_DR, CAPTURE_IR, EXIT2_DR, EXIT2_IR: return !(target inside {SHIFT_DR, SHIFT_IR});
    EXIT1_DR, EXIT1_IR: return !(target inside {PAUSE_DR, PAUSE_IR});
    UPDATE_DR, UPDATE_IR: return target != RUN_TEST_IDLE;
    default:          return 1'b1;
  endcase
endfunction

task automatic goto_state(input tap_state_t target);
  logic unused_bit;
  while (m_state != target) clock_cycle(tms_toward(m_state, target), 1'b0, unused_bit);
endtask

// Shift n bits through IR or DR, LSB first, and return to idle
task automatic scan_reg(input tap_state_t shift_state, input logic [63:0] din, input int n,
                        output logic [63:0] dout);
  logic b;
  dout = '0;
  goto_state(shift_state);
  for (int k = 0; k < n; k++) begin
    clock_cycle(k == n - 1, din[k], b);
    dout[k] = b;
  end
  goto_state(RUN_TEST_IDLE);
endtask

`endif

// File: verification/tb_jtag_tap.sv
`timescale 1ns/1ps

module tb_jtag_tap import jtag_pkg::*; ();

  localparam int N_IR     = 6;
  localparam int N_BYP    = 4;
  localparam int N_USR    = 6;
  localparam int N_WALK   = 8;
  localparam int WALK_LEN = 40;
  localparam int IR_CYC   = IR_LEN + 6;  // IR scan from idle, worst case
  // Upper bound on TCK cycles over all tests
  localparam int RUN_CYCLES = 10 + (IDCODE_LEN + 6) + N_IR * IR_CYC + N_BYP * (IR_CYC + 45)
    + 3 * IR_CYC + (N_USR + 1) * (USER_LEN + 6) + (IDCODE_LEN + 6)
    + N_WALK * (IR_CYC + USER_LEN + 6 + WALK_LEN + 5 + IDCODE_LEN + 6);

  logic                TCK = 1'b0;
  logic                TRST;
  logic                tms;
  logic                tdi;
  logic [USER_LEN-1:0] user_status;
  logic                tdo;
  logic                tdo_en;
  logic [USER_LEN-1:0] user_data;

  int          errors = 0;
  int          errors_before = 0;
  int          tests = 0;
  logic [15:0] lfsr = 16'd30;

  always #2 TCK = ~TCK;

  jtag_tap_top u_jtag_tap_top (
    .TCK         (TCK),
    .TRST        (TRST),
    .tms         (tms),
    .tdi         (tdi),
    .user_status (user_status),
    .tdo         (tdo),
    .tdo_en      (tdo_en),
    .user_data   (user_data)
  );

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    errors++;
    $display("Fail at %0.1f ns: %s expected %0h, got %0h", $realtime, name, exp, got);
  endtask

  `include "jtag_tap_model.svh"

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    return lfsr[0];
  endfunction

  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v[i] = next_bit();
    return v;
  endfunction

  task automatic finish_test(input string name);
    tests++;
    if (errors == errors_before) $display("Test %0d %s: ok", tests, name);
    else $display("Test %0d %s: %0d errors", tests, name, errors - errors_before);
    errors_before = errors;
  endtask

  initial begin
    logic [63:0]         din;
    logic [63:0]         dout;
    logic [63:0]         expv;
    logic [63:0]         mask;
    logic [IR_LEN-1:0]   code;
    logic [USER_LEN-1:0] held;
    int                  n;
    logic                t;
    logic                d;
    logic                unused_bit;
    TRST = 1'b0;
    tms = 1'b1;
    tdi = 1'b0;
    user_status = '0;
    reset_model();
    repeat (10) @(posedge TCK);
    #0.5;
    if (tdo !== 1'b0) report_mismatch("tdo", 64'd0, 64'(tdo));
    if (tdo_en !== 1'b0) report_mismatch("tdo_en", 64'd0, 64'(tdo_en));
    TRST = 1'b1;

    scan_reg(SHIFT_DR, random_bits(IDCODE_LEN), IDCODE_LEN, dout);
    if (dout !== 64'(IDCODE_VALUE)) report_mismatch("idcode scan", 64'(IDCODE_VALUE), dout);
    finish_test("reset default");

    for (int i = 0; i < N_IR; i++) begin
      scan_reg(SHIFT_IR, random_bits(IR_LEN), IR_LEN, dout);
      if (dout !== 64'(IR_CAPTURE)) report_mismatch("ir capture", 64'(IR_CAPTURE), dout);
    end
    finish_test("instruction capture");

    for (int i = 0; i < N_BYP; i++) begin
      code = OP_BYPASS;
      if (i % 2 == 1) begin
        do begin
          code = 5'(random_bits(IR_LEN));
        end while (code inside {OP_IDCODE, OP_USER, OP_BYPASS});
      end
      scan_reg(SHIFT_IR, 64'(code), IR_LEN, dout);
      n = 8 + int'(random_bits(5));
      din = random_bits(n);
      scan_reg(SHIFT_DR, din, n, dout);
      mask = (64'd1 << n) - 64'd1;
      expv = {din[62:0], 1'b0} & mask;  // One cycle late through the bypass bit
      if ((dout & mask) !== expv) report_mismatch("bypass tdo", expv, dout & mask);
    end
    finish_test("bypass");

    scan_reg(SHIFT_IR, 64'(OP_USER), IR_LEN, dout);
    for (int i = 0; i < N_USR; i++) begin
      user_status = 16'(random_bits(USER_LEN));
      din = random_bits(USER_LEN);
      scan_reg(SHIFT_DR, din, USER_LEN, dout);
      if (dout !== 64'(user_status)) report_mismatch("user status", 64'(user_status), dout);
      if (user_data !== din[USER_LEN-1:0]) report_mismatch("user_data", din, 64'(user_data));
    end
    held = user_data;
    scan_reg(SHIFT_IR, 64'(OP_BYPASS), IR_LEN, dout);
    scan_reg(SHIFT_DR, random_bits(USER_LEN), USER_LEN, dout);
    scan_reg(SHIFT_IR, 64'(OP_IDCODE), IR_LEN, dout);
    scan_reg(SHIFT_DR, random_bits(IDCODE_LEN), IDCODE_LEN, dout);
    if (user_data !== held) report_mismatch("held user_data", 64'(held), 64'(user_data));
    finish_test("user register");

    for (int w = 0; w < N_WALK; w++) begin
      scan_reg(SHIFT_IR, 64'(OP_USER), IR_LEN, dout);
      scan_reg(SHIFT_DR, random_bits(USER_LEN), USER_LEN, dout);
      for (int k = 0; k < WALK_LEN; k++) begin
        t = next_bit() & next_bit();  // TMS high one cycle in four
        d = next_bit();
        clock_cycle(t, d, unused_bit);
      end
      repeat (5) clock_cycle(1'b1, 1'b0, unused_bit);
      scan_reg(SHIFT_DR, random_bits(IDCODE_LEN), IDCODE_LEN, dout);
      if (dout !== 64'(IDCODE_VALUE)) begin
        report_mismatch("idcode after walk", 64'(IDCODE_VALUE), dout);
      end
      if (user_data !== '0) report_mismatch("user_data after walk", 64'd0, 64'(user_data));
    end
    finish_test("random TMS walks");

    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #((RUN_CYCLES + 100) * 4);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: build.f
+incdir+verification
src/jtag_pkg.sv
src/tap_fsm.sv
src/instr_reg.sv
src/idcode_reg.sv
src/user_reg.sv
src/scan_out_mux.sv
src/jtag_tap_top.sv
verification/jtag_tap_assert.sv
verification/tb_jtag_tap.sv

// File: Makefile
TOP = tb_jtag_tap
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	  if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
